//--- src/lockstep_pkg.sv
// --------------------------------------------------
// Lockstep scratchpad package
// Widths, copy depth and bank response state shared
// by the banks, the copy source and the top level
// --------------------------------------------------

package lockstep_pkg;

  // Memory geometry
  localparam int unsigned addr_w = 6;       // 64 words
  localparam int unsigned data_w = 32;
  localparam int unsigned be_w   = data_w / 8; // Byte lanes, also parity bits

  // Fault counter width, saturates at all ones
  localparam int unsigned cnt_w = 8;

  // How much of the request reaches the shadow bank
  typedef enum logic [1:0] {
    copy_full      = 2'd0, // Control, data and ECC
    copy_no_ecc    = 2'd1, // Control and data
    copy_no_data   = 2'd2, // Control and ECC
    copy_ctrl_only = 2'd3  // Control only
  } copy_mode_e;

  // Bank response register
  typedef enum logic {
    resp_idle = 1'b0, // Nothing pending
    resp_hold = 1'b1  // Response on r_valid, waiting for r_ready
  } bank_state_e;

  // Even parity of every byte lane
  function automatic logic [be_w-1:0] byte_parity(input logic [data_w-1:0] d);
    logic [be_w-1:0] p;
    for (int i = 0; i < be_w; i++) begin
      p[i] = ^d[i*8 +: 8];
    end
    return p;
  endfunction

endpackage

//--- src/tcdm_bank.sv
// --------------------------------------------------
// TCDM bank
// Single-cycle SRAM with byte enables, one parity
// bit per byte and a response register that holds
// its data while the initiator applies back-pressure
// --------------------------------------------------

`timescale 1ns/1ps

module tcdm_bank
  import lockstep_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // Request
  input  logic              req,
  input  logic              wen,     // High for read
  input  logic              ereq,    // Store supplied ecc instead of own parity
  input  logic [addr_w-1:0] add,
  input  logic [be_w-1:0]   be,
  input  logic [data_w-1:0] data,
  input  logic [be_w-1:0]   ecc,
  // Response
  input  logic              r_ready,
  output logic              gnt,
  output logic              r_valid,
  output logic [data_w-1:0] r_data,
  output logic [be_w-1:0]   r_ecc
);

  localparam int unsigned n_words = 1 << addr_w;

  // Storage
  logic [data_w-1:0] mem_q [n_words]; // Data words
  logic [be_w-1:0]   par_q [n_words]; // Parity per byte

  bank_state_e       state_q, state_d;
  logic              accept;
  logic [be_w-1:0]   wr_par;  // Parity to store on a write
  logic [data_w-1:0] r_data_q;
  logic [be_w-1:0]   r_ecc_q;

  // Grant rule, blocked only while a response is stuck
  assign gnt    = (state_q == resp_idle) | r_ready;
  assign accept = req & gnt;

  // Own parity unless the initiator brings its own
  assign wr_par = ereq ? ecc : byte_parity(data);

  // Next response state
  always_comb begin
    state_d = state_q;
    case (state_q)
      resp_idle: begin
        if (accept) state_d = resp_hold;
      end
      resp_hold: begin
        // Consumed and nothing new behind it
        if (r_ready && !accept) state_d = resp_idle;
      end
      default: state_d = resp_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= resp_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Byte-enable write into data and parity arrays
  always_ff @(posedge clk_i) begin
    if (accept && !wen) begin
      for (int i = 0; i < be_w; i++) begin
        if (be[i]) begin
          mem_q[add][i*8 +: 8] <= data[i*8 +: 8];
          par_q[add][i]        <= wr_par[i];
        end
      end
    end
  end

  // Response payload, loaded only on accept so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (wen) begin
        r_data_q <= mem_q[add];
        r_ecc_q  <= par_q[add];
      end else begin
        r_data_q <= '0; // Write ack carries no data
        r_ecc_q  <= '0;
      end
    end
  end

  assign r_valid = (state_q == resp_hold);
  assign r_data  = r_data_q;
  assign r_ecc   = r_ecc_q;

endmodule

//--- src/copy_source.sv
// --------------------------------------------------
// Copy source
// Mirrors the initiator request onto the shadow bank
// to the depth set by copy_mode, compares both bank
// responses and flags any difference one cycle later
// --------------------------------------------------

`timescale 1ns/1ps

module copy_source
  import lockstep_pkg::*;
#(
  parameter copy_mode_e copy_mode = copy_full
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Main request, watched only
  input  logic              req,
  input  logic [addr_w-1:0] add,
  input  logic              wen,
  input  logic [be_w-1:0]   be,
  input  logic [data_w-1:0] data,
  input  logic              r_ready,
  // Main response
  input  logic              gnt,
  input  logic              r_valid,
  input  logic [data_w-1:0] r_data,
  input  logic [be_w-1:0]   r_ecc,
  // Shadow request
  output logic              s_req,
  output logic [addr_w-1:0] s_add,
  output logic              s_wen,
  output logic [be_w-1:0]   s_be,
  output logic [data_w-1:0] s_data,
  output logic              s_ereq,
  output logic [be_w-1:0]   s_ecc,
  output logic              s_r_ready,
  // Shadow response
  input  logic              s_gnt,
  input  logic              s_r_valid,
  input  logic [data_w-1:0] s_r_data,
  input  logic [be_w-1:0]   s_r_ecc,
  // Self-test masks
  input  logic [data_w-1:0] inject_data,
  input  logic [be_w-1:0]   inject_ecc,
  output logic              fault_o
);

  localparam bit copy_data = (copy_mode == copy_full) || (copy_mode == copy_no_ecc);
  localparam bit copy_ecc  = (copy_mode == copy_full) || (copy_mode == copy_no_data);

  logic resp_chk;  // Either bank presents a response
  logic ctrl_fault, data_fault, ecc_fault;

  // Control always mirrored
  assign s_req     = req;
  assign s_add     = add;
  assign s_wen     = wen;
  assign s_be      = be;
  assign s_r_ready = r_ready;

  assign s_data = copy_data ? data : '0;

  // Parity of the main write data goes along, so the shadow keeps
  // matching ECC even when the data itself is not copied
  assign s_ereq = copy_ecc ? (req & ~wen) : 1'b0;
  assign s_ecc  = copy_ecc ? byte_parity(data) : '0;

  // Payload compared only when a response is out
  assign resp_chk = r_valid | s_r_valid;

  assign ctrl_fault = (gnt != s_gnt) | (r_valid != s_r_valid);
  assign data_fault = copy_data & resp_chk & (r_data != (s_r_data ^ inject_data));
  assign ecc_fault  = copy_ecc & resp_chk & (r_ecc != (s_r_ecc ^ inject_ecc));

  // Registered to keep the compare off the fault collector path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_o <= 1'b0;
    end else begin
      fault_o <= ctrl_fault | data_fault | ecc_fault;
    end
  end

endmodule

//--- src/fault_collector.sv
// --------------------------------------------------
// Fault collector
// Turns fault pulses into a sticky flag and a
// saturating count, both cleared by software
// --------------------------------------------------

`timescale 1ns/1ps

module fault_collector
  import lockstep_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fault_pulse, // One cycle per mismatch
  input  logic             clear,       // Wins over a pulse in the same cycle
  output logic             fault_flag,
  output logic [cnt_w-1:0] fault_count
);

  logic             flag_q;
  logic [cnt_w-1:0] count_q;
  logic             count_max;

  assign count_max = &count_q; // Stop at 255

  // Sticky flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_q <= 1'b0;
    end else if (clear) begin
      flag_q <= 1'b0;
    end else if (fault_pulse) begin
      flag_q <= 1'b1;
    end
  end

  // Saturating count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear) begin
      count_q <= '0;
    end else if (fault_pulse && !count_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign fault_flag  = flag_q;
  assign fault_count = count_q;

endmodule

//--- src/lockstep_mem_top.sv
// --------------------------------------------------
// Lockstep scratchpad port
// Main bank plus shadow bank fed by the copy source,
// with mismatches gathered by the fault collector
// --------------------------------------------------

`timescale 1ns/1ps

module lockstep_mem_top
  import lockstep_pkg::*;
#(
  parameter copy_mode_e copy_mode = copy_full
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Initiator port
  input  logic              req,
  input  logic [addr_w-1:0] add,
  input  logic              wen,
  input  logic [be_w-1:0]   be,
  input  logic [data_w-1:0] data,
  input  logic              r_ready,
  output logic              gnt,
  output logic              r_valid,
  output logic [data_w-1:0] r_data,
  output logic [be_w-1:0]   r_ecc,
  // Self-test and fault status
  input  logic [data_w-1:0] inject_data,
  input  logic [be_w-1:0]   inject_ecc,
  input  logic              fault_clear,
  output logic              fault_flag,
  output logic [cnt_w-1:0]  fault_count
);

  // Shadow port
  logic              s_req, s_wen, s_ereq, s_r_ready;
  logic [addr_w-1:0] s_add;
  logic [be_w-1:0]   s_be, s_ecc;
  logic [data_w-1:0] s_data;
  logic              s_gnt, s_r_valid;
  logic [data_w-1:0] s_r_data;
  logic [be_w-1:0]   s_r_ecc;

  logic fault;

  // Main bank makes its own parity
  tcdm_bank i_main (
    .clk_i, .rst_ni,
    .req, .wen, .ereq(1'b0), .add, .be, .data, .ecc('0),
    .r_ready, .gnt, .r_valid, .r_data, .r_ecc
  );

  tcdm_bank i_shadow (
    .clk_i, .rst_ni,
    .req(s_req), .wen(s_wen), .ereq(s_ereq), .add(s_add), .be(s_be),
    .data(s_data), .ecc(s_ecc), .r_ready(s_r_ready),
    .gnt(s_gnt), .r_valid(s_r_valid), .r_data(s_r_data), .r_ecc(s_r_ecc)
  );

  copy_source #(.copy_mode(copy_mode)) i_copy (
    .clk_i, .rst_ni,
    .req, .add, .wen, .be, .data, .r_ready,
    .gnt, .r_valid, .r_data, .r_ecc,
    .s_req, .s_add, .s_wen, .s_be, .s_data, .s_ereq, .s_ecc, .s_r_ready,
    .s_gnt, .s_r_valid, .s_r_data, .s_r_ecc,
    .inject_data, .inject_ecc,
    .fault_o(fault)
  );

  fault_collector i_faults (
    .clk_i, .rst_ni,
    .fault_pulse(fault), .clear(fault_clear),
    .fault_flag, .fault_count
  );

endmodule

//--- verif/tb_lockstep_mem.sv
// --------------------------------------------------
// Lockstep scratchpad testbench
// Directed tests against a reference memory, with
// fault injection, clear and LFSR random traffic
// --------------------------------------------------

`timescale 1ns/1ps

module tb_lockstep_mem
  import lockstep_pkg::*;
();

  localparam int          hs_limit   = 20;   // Cycles allowed per handshake
  localparam int          max_cycles = 4000; // Room for about 600 transactions of up to 5 cycles
  localparam logic [31:0] lfsr_seed  = 32'h597c_a609;
  localparam logic [31:0] lfsr_taps  = 32'ha300_0000; // x^32+x^30+x^26+x^25+1

  logic              clk_i;
  logic              rst_ni;
  logic              req, wen, r_ready;
  logic [addr_w-1:0] add;
  logic [be_w-1:0]   be;
  logic [data_w-1:0] data;
  logic              gnt, r_valid;
  logic [data_w-1:0] r_data;
  logic [be_w-1:0]   r_ecc;
  logic [data_w-1:0] inject_data;
  logic [be_w-1:0]   inject_ecc;
  logic              fault_clear, fault_flag;
  logic [cnt_w-1:0]  fault_count;

  logic [data_w-1:0] ref_mem [1 << addr_w]; // Expected word per address
  logic [31:0]       lfsr_q;
  int                cycles;
  string             cur_test;
  bank_state_e       main_state; // Main bank response state shown in waves

  assign main_state = i_dut.i_main.state_q;

  lockstep_mem_top #(.copy_mode(copy_full)) i_dut (
    .clk_i, .rst_ni,
    .req, .add, .wen, .be, .data, .r_ready,
    .gnt, .r_valid, .r_data, .r_ecc,
    .inject_data, .inject_ecc,
    .fault_clear, .fault_flag, .fault_count
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Global run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("Run exceeded %0d cycles and was stopped", max_cycles);
      stop_run();
    end
  end

  task automatic compare_data(input string what, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s.%s expected %h actual %h", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_ecc(input string what, input logic [be_w-1:0] exp,
                             input logic [be_w-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s.%s expected %b actual %b", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_count(input string what, input logic [cnt_w-1:0] exp,
                               input logic [cnt_w-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s.%s expected %0d actual %0d", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s.%s expected %b actual %b", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_taps) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // Even parity per byte lane computed bit by bit
  function automatic logic [be_w-1:0] lane_parity(input logic [data_w-1:0] w);
    logic [be_w-1:0] p;
    p = '0;
    for (int l = 0; l < be_w; l++) begin
      for (int b = 0; b < 8; b++) begin
        p[l] = p[l] ^ w[l*8 + b];
      end
    end
    return p;
  endfunction

  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old,
                                                    input logic [data_w-1:0] nw,
                                                    input logic [be_w-1:0] lanes);
    logic [data_w-1:0] res;
    res = old;
    for (int l = 0; l < be_w; l++) begin
      if (lanes[l]) res[l*8 +: 8] = nw[l*8 +: 8]; // Enabled lane only
    end
    return res;
  endfunction

  // One request and its response from just after a rising edge
  task automatic transact(input logic do_write, input logic [addr_w-1:0] a,
                          input logic [be_w-1:0] b, input logic [data_w-1:0] d,
                          input int stall, output logic [data_w-1:0] rd,
                          output logic [be_w-1:0] re);
    int                wait_n;
    logic [data_w-1:0] held_data;
    logic [be_w-1:0]   held_ecc;
    req     <= 1'b1;
    wen     <= ~do_write; // High means read
    add     <= a;
    be      <= b;
    data    <= d;
    r_ready <= (stall == 0);
    wait_n = 0;
    @(negedge clk_i);
    while (!gnt) begin
      wait_n++;
      if (wait_n > hs_limit) begin
        $display("%s stalled, gnt never came for the request", cur_test);
        stop_run();
      end
      @(posedge clk_i);
      @(negedge clk_i);
    end
    @(posedge clk_i); // Accepted on this edge
    req <= 1'b0;
    wait_n = 0;
    @(negedge clk_i);
    while (!r_valid) begin
      wait_n++;
      if (wait_n > hs_limit) begin
        $display("%s stalled, r_valid never came after the grant", cur_test);
        stop_run();
      end
      @(posedge clk_i);
      @(negedge clk_i);
    end
    if (wait_n != 0) begin
      $display("%s response arrived %0d cycles later than one cycle", cur_test, wait_n);
      stop_run();
    end
    held_data = r_data;
    held_ecc  = r_ecc;
    wait_n    = 0;
    // Under back-pressure the response sits still and blocks new grants
    while (!r_ready) begin
      compare_flag("r_valid", 1'b1, r_valid);
      compare_flag("gnt", 1'b0, gnt);
      compare_flag("hold", 1'b1, main_state == resp_hold);
      compare_data("held r_data", held_data, r_data);
      compare_ecc("held r_ecc", held_ecc, r_ecc);
      @(posedge clk_i);
      wait_n++;
      if (wait_n >= stall) r_ready <= 1'b1;
      @(negedge clk_i);
    end
    compare_flag("r_valid", 1'b1, r_valid);
    compare_data("held r_data", held_data, r_data);
    rd = r_data;
    re = r_ecc;
    @(posedge clk_i); // Consumed here
  endtask

  task automatic write_word(input logic [addr_w-1:0] a, input logic [be_w-1:0] b,
                            input logic [data_w-1:0] d, input int stall);
    logic [data_w-1:0] rd;
    logic [be_w-1:0]   re;
    ref_mem[a] = merge_bytes(ref_mem[a], d, b);
    transact(1'b1, a, b, d, stall, rd, re);
    compare_data("write r_data", '0, rd); // Write ack is empty
    compare_ecc("write r_ecc", '0, re);
  endtask

  task automatic read_check(input logic [addr_w-1:0] a, input int stall);
    logic [data_w-1:0] rd;
    logic [be_w-1:0]   re;
    transact(1'b0, a, '1, '0, stall, rd, re);
    compare_data("r_data", ref_mem[a], rd);
    compare_ecc("r_ecc", lane_parity(ref_mem[a]), re);
  endtask

  // Pulse of the last response reaches the collector one edge after it is consumed
  task automatic check_status(input logic f, input logic [cnt_w-1:0] c);
    @(posedge clk_i);
    @(negedge clk_i); // Sampled mid-cycle
    compare_flag("fault_flag", f, fault_flag);
    compare_count("fault_count", c, fault_count);
    @(posedge clk_i);
  endtask

  task automatic write_read();
    logic [31:0]       r;
    logic [addr_w-1:0] a;
    int                k;
    cur_test = "write_read";
    for (int i = 0; i < 4; i++) begin
      k = i * 19 + 3;
      a = k[addr_w-1:0];
      write_word(a, '1, rand_bits(data_w), 0); // Full word first
      r = rand_bits(be_w);
      write_word(a, r[be_w-1:0], rand_bits(data_w), 0); // Then a partial
    end
    for (int i = 0; i < 4; i++) begin
      k = i * 19 + 3;
      a = k[addr_w-1:0];
      read_check(a, 0);
    end
    check_status(1'b0, '0);
  endtask

  task automatic hold_under_backpressure();
    cur_test = "backpressure";
    write_word(6'd33, '1, rand_bits(data_w), 2); // Write ack held too
    read_check(6'd33, 3);
    check_status(1'b0, '0);
  endtask

  task automatic inject_data_fault();
    cur_test = "inject_data";
    write_word(6'd9, '1, 32'hc3a5_5a3c, 0);
    inject_data <= 32'h0001_0000; // Single bit in lane 2
    read_check(6'd9, 0);
    inject_data <= '0;
    check_status(1'b1, 8'd1);
    read_check(6'd9, 0);
    check_status(1'b1, 8'd1); // Clean read adds nothing
  endtask

  task automatic inject_ecc_fault();
    cur_test = "inject_ecc";
    write_word(6'd9, '1, 32'h5a3c_c3a5, 0);
    inject_ecc <= 4'b0100;
    read_check(6'd9, 0);
    inject_ecc <= '0;
    check_status(1'b1, 8'd2);
    read_check(6'd9, 0);
    check_status(1'b1, 8'd2);
  endtask

  task automatic clear_faults();
    cur_test = "clear";
    fault_clear <= 1'b1;
    @(posedge clk_i);
    fault_clear <= 1'b0;
    check_status(1'b0, '0);
  endtask

  task automatic random_traffic();
    logic [31:0]       r;
    logic [addr_w-1:0] a;
    logic [be_w-1:0]   lanes;
    logic              wr;
    int                stall;
    cur_test = "random_traffic";
    for (int i = 0; i < (1 << addr_w); i++) begin
      a = i[addr_w-1:0];
      write_word(a, '1, rand_bits(data_w), 0); // Whole memory defined
    end
    for (int n = 0; n < 500; n++) begin
      r     = rand_bits(1);
      wr    = r[0];
      r     = rand_bits(addr_w);
      a     = r[addr_w-1:0];
      r     = rand_bits(be_w);
      lanes = r[be_w-1:0];
      r     = rand_bits(2);
      stall = int'(r[1:0]); // 0 to 3 cycles of back-pressure
      if (wr) begin
        write_word(a, lanes, rand_bits(data_w), stall);
      end else begin
        read_check(a, stall);
      end
    end
    check_status(1'b0, '0);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req         = 1'b0;
    wen         = 1'b1;
    add         = '0;
    be          = '0;
    data        = '0;
    r_ready     = 1'b1;
    inject_data = '0;
    inject_ecc  = '0;
    fault_clear = 1'b0;
    lfsr_q      = lfsr_seed;
    cycles      = 0;
    cur_test    = "reset";
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare_flag("gnt", 1'b1, gnt);
    compare_flag("r_valid", 1'b0, r_valid);
    @(posedge clk_i);
    check_status(1'b0, '0);
    write_read();
    hold_under_backpressure();
    inject_data_fault();
    inject_ecc_fault();
    clear_faults();
    random_traffic();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- compile.f
src/lockstep_pkg.sv
src/tcdm_bank.sv
src/copy_source.sv
src/fault_collector.sv
src/lockstep_mem_top.sv
verif/tb_lockstep_mem.sv

//--- Makefile
# Verilator build, run and lint for the lockstep scratchpad

VERILATOR ?= verilator
TB_TOP    ?= tb_lockstep_mem
RTL_TOP   ?= lockstep_mem_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing -j $(JOBS)
PASS_MSG  ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TB_TOP) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
